/* cpu_decode_settings.svh */
`ifndef CPU_DECODE_SETTINGS_SVH
`define CPU_DECODE_SETTINGS_SVH

`define DATA_W 8
`define ADDR_W 16

// Status register bit positions
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_V 6
`define FLAG_N 7

`define TRACE_LINES 35                  // Rows in decode_trace.txt

// Implied
`define OP_NOP 8'hEA
`define OP_SEC 8'h38
`define OP_CLC 8'h18
`define OP_CLV 8'hB8
`define OP_TAX 8'hAA
`define OP_TAY 8'hA8
`define OP_TXA 8'h8A
`define OP_TYA 8'h98

// Immediate loads
`define OP_LDA_IMM 8'hA9
`define OP_LDX_IMM 8'hA2
`define OP_LDY_IMM 8'hA0

// Accumulator and register ALU
`define OP_ASL_A 8'h0A
`define OP_LSR_A 8'h4A
`define OP_ROL_A 8'h2A
`define OP_ROR_A 8'h6A
`define OP_INX   8'hE8
`define OP_INY   8'hC8
`define OP_DEX   8'hCA
`define OP_DEY   8'h88

// Zero page. The absolute form is the same byte with OP_ABS_BIT set
`define OP_ABS_BIT 3
`define OP_LDA_ZPG 8'hA5
`define OP_LDX_ZPG 8'hA6
`define OP_LDY_ZPG 8'hA4
`define OP_STA_ZPG 8'h85
`define OP_STX_ZPG 8'h86
`define OP_STY_ZPG 8'h84
`define OP_ASL_ZPG 8'h06
`define OP_LSR_ZPG 8'h46
`define OP_ROL_ZPG 8'h26
`define OP_ROR_ZPG 8'h66
`define OP_INC_ZPG 8'hE6
`define OP_DEC_ZPG 8'hC6
`define OP_AND_ZPG 8'h25
`define OP_ORA_ZPG 8'h05
`define OP_EOR_ZPG 8'h45
`define OP_ADC_ZPG 8'h65
`define OP_SBC_ZPG 8'hE5
`define OP_CMP_ZPG 8'hC5

`define OP_JMP_ABS 8'h4C

`endif

/* cpu_decode_pkg.sv */
`include "cpu_decode_settings.svh"

package cpu_decode_pkg;

    typedef enum logic [3:0] {
        ST_IDLE             = 4'd0,
        ST_OPCODE_READ      = 4'd1,
        ST_ZPG_ABS_ADR_READ = 4'd2,
        ST_IDL_DATA_WRITE   = 4'd3,
        ST_SPARE            = 4'd4,
        ST_ALU_FINAL        = 4'd5,
        ST_DBUF_OUTPUT      = 4'd6,
        ST_ALU_TMX          = 4'd7,
        ST_ABS_LB           = 4'd8,
        ST_ABS_HB           = 4'd9,
        ST_PC_LOAD          = 4'd10
    } decode_state_e;

    typedef enum logic [2:0] {
        MODE_IMPLIED, MODE_IMMEDIATE, MODE_ACCUM, MODE_ZPG, MODE_ABS
    } addr_mode_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR,
        ALU_AND, ALU_OR,  ALU_XOR, ALU_ADD, ALU_SUB,
        ALU_CMP, ALU_INC, ALU_DEC, ALU_FLG, ALU_TMX
    } alu_op_e;

    typedef enum logic [1:0] {BUF_IDLE = 2'd0, BUF_LOAD = 2'd1, BUF_STORE = 2'd2} buf_ctl_e;
    typedef enum logic [1:0] {PC_HOLD = 2'd0, PC_INC = 2'd1, PC_LOAD = 2'd2} pc_ctl_e;
    typedef enum logic [1:0] {SEL_NONE, SEL_A, SEL_X, SEL_Y} reg_sel_e;

    typedef struct packed {
        logic en;
        logic rd_wr_n;          // 1 drives the bus, 0 loads from it
        logic bus;              // 0 bus one, 1 bus two
    } reg_ctl_t;

    localparam reg_ctl_t RC_IDLE   = '{en: 1'b0, rd_wr_n: 1'b0, bus: 1'b0};
    localparam reg_ctl_t RC_LOAD1  = '{en: 1'b1, rd_wr_n: 1'b0, bus: 1'b0};
    localparam reg_ctl_t RC_STORE1 = '{en: 1'b1, rd_wr_n: 1'b1, bus: 1'b0};
    localparam reg_ctl_t RC_LOAD2  = '{en: 1'b1, rd_wr_n: 1'b0, bus: 1'b1};
    localparam reg_ctl_t RC_STORE2 = '{en: 1'b1, rd_wr_n: 1'b1, bus: 1'b1};

    // For implied opcodes alu carries the flag command
    typedef struct packed {
        addr_mode_e mode;
        alu_op_e    alu;
        reg_sel_e   src;
        reg_sel_e   dst;
        logic       writes_mem;
        logic       is_jump;
    } op_class_t;

    typedef struct packed {
        logic [6:0]         mask;
        logic [`DATA_W-1:0] value;
        logic               rw;
    } status_upd_t;

    typedef struct packed {
        logic [1:0]         addr_sel;   // 0 PC, 1 operand address
        logic               rw;         // 1 read, 0 write
        logic [`ADDR_W-1:0] addr;
    } mem_ctl_t;

endpackage

/* opcode_classify.sv */
`timescale 1ns/1ps
`include "cpu_decode_settings.svh"

module opcode_classify import cpu_decode_pkg::*; (
    input  logic [`DATA_W-1:0] opcode,
    output op_class_t          op_class
);

    localparam op_class_t NOP_CLASS = '{MODE_IMPLIED, ALU_NOP, SEL_NONE, SEL_NONE, 1'b0, 1'b0};

    addr_mode_e         mem_mode;
    logic [`DATA_W-1:0] zpg_code;
    op_class_t          mem_class;

    assign mem_mode = opcode[`OP_ABS_BIT] ? MODE_ABS : MODE_ZPG;

    always_comb begin
        zpg_code = opcode;
        zpg_code[`OP_ABS_BIT] = 1'b0;   // Fold absolute onto zero page
    end

    always_comb begin
        mem_class = NOP_CLASS;
        case (zpg_code)
            `OP_LDA_ZPG: mem_class = '{mem_mode, ALU_FLG, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_LDX_ZPG: mem_class = '{mem_mode, ALU_FLG, SEL_NONE, SEL_X, 1'b0, 1'b0};
            `OP_LDY_ZPG: mem_class = '{mem_mode, ALU_FLG, SEL_NONE, SEL_Y, 1'b0, 1'b0};
            `OP_STA_ZPG: mem_class = '{mem_mode, ALU_NOP, SEL_A, SEL_NONE, 1'b1, 1'b0};
            `OP_STX_ZPG: mem_class = '{mem_mode, ALU_NOP, SEL_X, SEL_NONE, 1'b1, 1'b0};
            `OP_STY_ZPG: mem_class = '{mem_mode, ALU_NOP, SEL_Y, SEL_NONE, 1'b1, 1'b0};
            `OP_ASL_ZPG: mem_class = '{mem_mode, ALU_ASL, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_LSR_ZPG: mem_class = '{mem_mode, ALU_LSR, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_ROL_ZPG: mem_class = '{mem_mode, ALU_ROL, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_ROR_ZPG: mem_class = '{mem_mode, ALU_ROR, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_INC_ZPG: mem_class = '{mem_mode, ALU_INC, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_DEC_ZPG: mem_class = '{mem_mode, ALU_DEC, SEL_NONE, SEL_NONE, 1'b1, 1'b0};
            `OP_AND_ZPG: mem_class = '{mem_mode, ALU_AND, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_ORA_ZPG: mem_class = '{mem_mode, ALU_OR, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_EOR_ZPG: mem_class = '{mem_mode, ALU_XOR, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_ADC_ZPG: mem_class = '{mem_mode, ALU_ADD, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_SBC_ZPG: mem_class = '{mem_mode, ALU_SUB, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_CMP_ZPG: mem_class = '{mem_mode, ALU_CMP, SEL_NONE, SEL_NONE, 1'b0, 1'b0};
            default: ;
        endcase
    end

    always_comb begin
        op_class = NOP_CLASS;
        case (opcode)
            `OP_NOP: ;                              // Default class already is NOP
            `OP_SEC: op_class.alu = ALU_INC;        // Set C
            `OP_CLC: op_class.alu = ALU_DEC;        // Clear C
            `OP_CLV: op_class.alu = ALU_FLG;        // Clear V
            `OP_TAX: op_class = '{MODE_IMPLIED, ALU_NOP, SEL_A, SEL_X, 1'b0, 1'b0};
            `OP_TAY: op_class = '{MODE_IMPLIED, ALU_NOP, SEL_A, SEL_Y, 1'b0, 1'b0};
            `OP_TXA: op_class = '{MODE_IMPLIED, ALU_NOP, SEL_X, SEL_A, 1'b0, 1'b0};
            `OP_TYA: op_class = '{MODE_IMPLIED, ALU_NOP, SEL_Y, SEL_A, 1'b0, 1'b0};
            `OP_LDA_IMM: op_class = '{MODE_IMMEDIATE, ALU_FLG, SEL_NONE, SEL_A, 1'b0, 1'b0};
            `OP_LDX_IMM: op_class = '{MODE_IMMEDIATE, ALU_FLG, SEL_NONE, SEL_X, 1'b0, 1'b0};
            `OP_LDY_IMM: op_class = '{MODE_IMMEDIATE, ALU_FLG, SEL_NONE, SEL_Y, 1'b0, 1'b0};
            `OP_ASL_A: op_class = '{MODE_ACCUM, ALU_ASL, SEL_A, SEL_A, 1'b0, 1'b0};
            `OP_LSR_A: op_class = '{MODE_ACCUM, ALU_LSR, SEL_A, SEL_A, 1'b0, 1'b0};
            `OP_ROL_A: op_class = '{MODE_ACCUM, ALU_ROL, SEL_A, SEL_A, 1'b0, 1'b0};
            `OP_ROR_A: op_class = '{MODE_ACCUM, ALU_ROR, SEL_A, SEL_A, 1'b0, 1'b0};
            `OP_INX: op_class = '{MODE_ACCUM, ALU_INC, SEL_X, SEL_X, 1'b0, 1'b0};
            `OP_INY: op_class = '{MODE_ACCUM, ALU_INC, SEL_Y, SEL_Y, 1'b0, 1'b0};
            `OP_DEX: op_class = '{MODE_ACCUM, ALU_DEC, SEL_X, SEL_X, 1'b0, 1'b0};
            `OP_DEY: op_class = '{MODE_ACCUM, ALU_DEC, SEL_Y, SEL_Y, 1'b0, 1'b0};
            `OP_JMP_ABS: op_class = '{MODE_ABS, ALU_NOP, SEL_NONE, SEL_NONE, 1'b0, 1'b1};
            default: begin
                // Address field 001 is zero page, 011 absolute
                if (opcode[4:2] == 3'b001 || opcode[4:2] == 3'b011) begin
                    op_class = mem_class;
                end
            end
        endcase
    end

endmodule

/* decode_fsm.sv */
`timescale 1ns/1ps
`include "cpu_decode_settings.svh"

module decode_fsm import cpu_decode_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,
    input  logic [`DATA_W-1:0] instruction,
    input  op_class_t          next_class,
    output decode_state_e      state,
    output op_class_t          op_class,
    output logic [`ADDR_W-1:0] operand_addr
);

    decode_state_e next_state;

    always_comb begin
        next_state = ST_IDLE;
        case (state)
            ST_IDLE: next_state = ST_OPCODE_READ;
            ST_OPCODE_READ: begin
                case (op_class.mode)
                    MODE_IMMEDIATE: next_state = ST_IDL_DATA_WRITE;
                    MODE_ACCUM:     next_state = ST_ALU_FINAL;    // Operands already in registers
                    MODE_ZPG:       next_state = ST_ZPG_ABS_ADR_READ;
                    MODE_ABS:       next_state = ST_ABS_LB;
                    default:        next_state = ST_IDLE;         // Implied ends here
                endcase
            end
            ST_ZPG_ABS_ADR_READ: next_state = ST_IDL_DATA_WRITE;
            ST_IDL_DATA_WRITE:   next_state = ST_ALU_FINAL;
            ST_ALU_FINAL:        next_state = ST_ALU_TMX;
            ST_ALU_TMX: begin
                if (op_class.writes_mem) begin
                    next_state = ST_DBUF_OUTPUT;
                end else begin
                    next_state = ST_IDLE;
                end
            end
            ST_ABS_LB: begin
                if (op_class.is_jump) begin
                    next_state = ST_PC_LOAD;              // Next byte is the target high byte
                end else begin
                    next_state = ST_ABS_HB;
                end
            end
            ST_ABS_HB:      next_state = ST_IDL_DATA_WRITE;
            ST_DBUF_OUTPUT: next_state = ST_IDLE;
            ST_PC_LOAD:     next_state = ST_IDLE;
            ST_SPARE:       next_state = ST_IDLE;
            default:        next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            op_class <= '{MODE_IMPLIED, ALU_NOP, SEL_NONE, SEL_NONE, 1'b0, 1'b0};
        end else if (clk_enable) begin
            state <= next_state;
            if (next_state == ST_OPCODE_READ) begin
                op_class <= next_class;               // Byte on the bus now is the opcode
            end
        end
    end

    // Operand bytes arrive low byte first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operand_addr <= '0;
        end else if (clk_enable) begin
            case (next_state)
                ST_ZPG_ABS_ADR_READ, ST_ABS_LB: begin
                    operand_addr <= {{(`ADDR_W - `DATA_W){1'b0}}, instruction};
                end
                ST_ABS_HB, ST_PC_LOAD: begin
                    operand_addr[`ADDR_W-1 -: `DATA_W] <= instruction;
                end
                default: ;
            endcase
        end
    end

endmodule

/* control_gen.sv */
`timescale 1ns/1ps
`include "cpu_decode_settings.svh"

module control_gen import cpu_decode_pkg::*; (
    input  decode_state_e      state,
    input  op_class_t          op_class,
    input  logic [`ADDR_W-1:0] operand_addr,
    output status_upd_t        status_upd,
    output mem_ctl_t           mem_ctl,
    output pc_ctl_e            pc_ctl,
    output alu_op_e            alu_op,
    output buf_ctl_e           data_buffer,
    output buf_ctl_e           input_latch,
    output reg_ctl_t           reg_a,
    output reg_ctl_t           reg_x,
    output reg_ctl_t           reg_y
);

    // P bit 5 has no write line, so bits 6 and 7 sit one lower in the mask
    function automatic logic [6:0] flag_mask(input int unsigned pos);
        logic [6:0] m;
        m = '0;
        m[(pos > 5) ? pos - 1 : pos] = 1'b1;
        return m;
    endfunction

    // Destination wins when one register is both source and destination
    function automatic reg_ctl_t route(
        input reg_sel_e me,
        input reg_sel_e src_sel,
        input reg_ctl_t src_ctl,
        input reg_sel_e dst_sel,
        input reg_ctl_t dst_ctl
    );
        if (dst_sel == me && dst_ctl.en) begin
            return dst_ctl;
        end else if (src_sel == me && src_ctl.en) begin
            return src_ctl;
        end
        return RC_IDLE;
    endfunction

    localparam logic [6:0] MASK_C  = flag_mask(`FLAG_C);
    localparam logic [6:0] MASK_V  = flag_mask(`FLAG_V);
    localparam logic [6:0] MASK_ZN = flag_mask(`FLAG_Z) | flag_mask(`FLAG_N);

    reg_sel_e src_sel;
    reg_sel_e dst_sel;
    reg_ctl_t src_ctl;
    reg_ctl_t dst_ctl;
    logic     two_operand;
    logic     sets_carry;

    assign two_operand = op_class.alu inside {ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_CMP};
    assign sets_carry  = op_class.alu inside {ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_CMP};

    always_comb begin
        status_upd  = '{mask: '0, value: '0, rw: 1'b1};
        mem_ctl     = '{addr_sel: 2'd0, rw: 1'b1, addr: '0};
        pc_ctl      = PC_HOLD;
        alu_op      = ALU_NOP;
        data_buffer = BUF_IDLE;
        input_latch = BUF_IDLE;
        src_sel     = op_class.src;
        dst_sel     = op_class.dst;
        src_ctl     = RC_IDLE;
        dst_ctl     = RC_IDLE;
        case (state)
            ST_OPCODE_READ: begin
                pc_ctl = PC_INC;
                if (op_class.mode == MODE_IMPLIED) begin
                    case (op_class.alu)
                        ALU_INC: begin                      // SEC
                            status_upd.mask = MASK_C;
                            status_upd.value[`FLAG_C] = 1'b1;
                        end
                        ALU_DEC: status_upd.mask = MASK_C;  // CLC
                        ALU_FLG: status_upd.mask = MASK_V;  // CLV
                        default: begin
                            src_ctl = RC_STORE1;            // Transfer over bus one
                            dst_ctl = RC_LOAD1;
                        end
                    endcase
                end
            end
            ST_ZPG_ABS_ADR_READ, ST_ABS_HB: begin
                pc_ctl           = PC_INC;
                mem_ctl.addr_sel = 2'd1;
                mem_ctl.addr     = operand_addr;
            end
            ST_ABS_LB:         pc_ctl = PC_INC;
            ST_IDL_DATA_WRITE: input_latch = BUF_LOAD;
            ST_ALU_FINAL: begin
                status_upd.rw = 1'b0;
                alu_op        = op_class.alu;
                if (op_class.alu != ALU_NOP) begin
                    status_upd.mask = sets_carry ? (MASK_C | MASK_ZN) : MASK_ZN;
                    if (op_class.mode == MODE_ACCUM) begin
                        src_ctl = RC_STORE1;
                    end else begin
                        input_latch = BUF_STORE;
                    end
                    if (two_operand) begin
                        src_sel = SEL_A;            // Accumulator is the second operand
                        src_ctl = RC_STORE2;
                    end
                end
            end
            ST_ALU_TMX: begin
                if (op_class.dst != SEL_NONE) begin
                    dst_ctl = RC_LOAD2;
                    alu_op  = ALU_TMX;
                end else if (op_class.alu == ALU_NOP) begin
                    src_ctl     = RC_STORE2;        // Store
                    data_buffer = BUF_LOAD;
                end else if (op_class.alu != ALU_CMP) begin
                    data_buffer = BUF_LOAD;         // Read-modify-write result
                    alu_op      = ALU_TMX;
                end
            end
            ST_DBUF_OUTPUT: begin
                data_buffer      = BUF_STORE;
                mem_ctl.addr_sel = 2'd1;
                mem_ctl.rw       = 1'b0;
                mem_ctl.addr     = operand_addr;
            end
            ST_PC_LOAD: begin
                pc_ctl       = PC_LOAD;
                mem_ctl.addr = operand_addr;
            end
            default: ;
        endcase
    end

    assign reg_a = route(SEL_A, src_sel, src_ctl, dst_sel, dst_ctl);
    assign reg_x = route(SEL_X, src_sel, src_ctl, dst_sel, dst_ctl);
    assign reg_y = route(SEL_Y, src_sel, src_ctl, dst_sel, dst_ctl);

endmodule

/* instruction_decode.sv */
`timescale 1ns/1ps
`include "cpu_decode_settings.svh"

module instruction_decode import cpu_decode_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,
    input  logic [`DATA_W-1:0] instruction,
    output status_upd_t        status_upd,
    output mem_ctl_t           mem_ctl,
    output pc_ctl_e            pc_ctl,
    output alu_op_e            alu_op,
    output buf_ctl_e           data_buffer,
    output buf_ctl_e           input_latch,
    output reg_ctl_t           reg_a,
    output reg_ctl_t           reg_x,
    output reg_ctl_t           reg_y
);

    op_class_t          next_class;     // Class of the byte on the bus
    op_class_t          op_class;       // Class of the instruction in flight
    decode_state_e      state;
    logic [`ADDR_W-1:0] operand_addr;

    opcode_classify u_classify (
        .opcode   (instruction),
        .op_class (next_class)
    );

    decode_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_enable   (clk_enable),
        .instruction  (instruction),
        .next_class   (next_class),
        .state        (state),
        .op_class     (op_class),
        .operand_addr (operand_addr)
    );

    control_gen u_ctl (
        .state        (state),
        .op_class     (op_class),
        .operand_addr (operand_addr),
        .status_upd   (status_upd),
        .mem_ctl      (mem_ctl),
        .pc_ctl       (pc_ctl),
        .alu_op       (alu_op),
        .data_buffer  (data_buffer),
        .input_latch  (input_latch),
        .reg_a        (reg_a),
        .reg_x        (reg_x),
        .reg_y        (reg_y)
    );

endmodule

/* tb_instruction_decode.sv */
`timescale 1ns/1ps
`include "cpu_decode_settings.svh"

module tb_instruction_decode
    import cpu_decode_pkg::*;
();

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 8;
    localparam int READ_LIMIT   = 200;     // Lines scanned before the read gives up
    localparam int IDLE_LIMIT   = 20;

    // Control outputs of one cycle, in trace column order
    typedef struct packed {
        logic [6:0]         mask;
        logic [`DATA_W-1:0] value;
        logic               status_rw;
        logic [1:0]         addr_sel;
        logic               mem_rw;
        logic [`ADDR_W-1:0] addr;
        logic [1:0]         pc;
        logic [4:0]         alu;
        logic [1:0]         dbuf;
        logic [1:0]         ilat;
        logic [2:0]         a;
        logic [2:0]         x;
        logic [2:0]         y;
    } ctl_row_t;

    logic               clk;
    logic               rst_n;
    logic               clk_enable;
    logic [`DATA_W-1:0] instruction;

    status_upd_t status_upd;
    mem_ctl_t    mem_ctl;
    pc_ctl_e     pc_ctl;
    alu_op_e     alu_op;
    buf_ctl_e    data_buffer;
    buf_ctl_e    input_latch;
    reg_ctl_t    reg_a;
    reg_ctl_t    reg_x;
    reg_ctl_t    reg_y;
    ctl_row_t    observed;

    string              row_name [`TRACE_LINES];
    logic               row_ce   [`TRACE_LINES];
    logic [`DATA_W-1:0] row_ins  [`TRACE_LINES];
    ctl_row_t           row_exp  [`TRACE_LINES];
    int                 test_errors [string];

    int rows_loaded    = 0;
    int checks         = 0;
    int errors         = 0;
    int other_failures = 0;
    int tests_run      = 0;
    int tests_failed   = 0;
    int cur_row        = 0;

    instruction_decode u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .instruction (instruction),
        .status_upd  (status_upd),
        .mem_ctl     (mem_ctl),
        .pc_ctl      (pc_ctl),
        .alu_op      (alu_op),
        .data_buffer (data_buffer),
        .input_latch (input_latch),
        .reg_a       (reg_a),
        .reg_x       (reg_x),
        .reg_y       (reg_y)
    );

    assign observed = '{status_upd.mask, status_upd.value, status_upd.rw, mem_ctl.addr_sel,
                        mem_ctl.rw, mem_ctl.addr, pc_ctl, alu_op, data_buffer, input_latch,
                        reg_a, reg_x, reg_y};

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors[test] = test_errors[test] + 1;
            $display("ERROR %s row %0d %s: expected %0h, actual %0h",
                     test, cur_row, field, expected, actual);
        end
    endtask

    task automatic load_trace();
        int                 fd;
        int                 got;
        int                 scanned;
        string              line;
        string              name;
        logic               ce;
        logic [`DATA_W-1:0] ins;
        logic [6:0]         mask;
        logic [`DATA_W-1:0] value;
        logic               srw;
        logic [1:0]         asel;
        logic               mrw;
        logic [`ADDR_W-1:0] addr;
        logic [1:0]         pc;
        logic [4:0]         alu;
        logic [1:0]         dbuf;
        logic [1:0]         ilat;
        logic [2:0]         ra;
        logic [2:0]         rx;
        logic [2:0]         ry;
        scanned = 0;
        fd = $fopen("decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open decode_trace.txt");
            other_failures++;
        end else begin
            while (!$feof(fd) && rows_loaded < `TRACE_LINES && scanned < READ_LIMIT) begin
                scanned++;
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin   // Skip comments
                    got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  name, ce, ins, mask, value, srw, asel, mrw, addr,
                                  pc, alu, dbuf, ilat, ra, rx, ry);
                    if (got == 16) begin
                        row_name[rows_loaded] = name;
                        row_ce[rows_loaded]   = ce;
                        row_ins[rows_loaded]  = ins;
                        row_exp[rows_loaded]  = '{mask, value, srw, asel, mrw, addr,
                                                  pc, alu, dbuf, ilat, ra, rx, ry};
                        test_errors[name]     = 0;
                        rows_loaded++;
                    end else begin
                        $display("Malformed trace line: %s", line);
                        other_failures++;
                    end
                end
            end
            $fclose(fd);
            if (scanned >= READ_LIMIT) begin
                $display("Timed out after %0d lines reading decode_trace.txt", scanned);
                other_failures++;
            end
            if (rows_loaded != `TRACE_LINES) begin
                $display("Trace holds %0d rows but %0d were expected", rows_loaded, `TRACE_LINES);
                other_failures++;
            end
        end
    endtask

    task automatic check_row(input int r);
        string    t;
        ctl_row_t e;
        t       = row_name[r];
        e       = row_exp[r];
        cur_row = r;
        check_value(t, "status mask", 32'(e.mask), 32'(observed.mask));
        check_value(t, "status value", 32'(e.value), 32'(observed.value));
        check_value(t, "status rw", 32'(e.status_rw), 32'(observed.status_rw));
        check_value(t, "address_select", 32'(e.addr_sel), 32'(observed.addr_sel));
        check_value(t, "mem rw", 32'(e.mem_rw), 32'(observed.mem_rw));
        check_value(t, "address", 32'(e.addr), 32'(observed.addr));
        check_value(t, "pc", 32'(e.pc), 32'(observed.pc));
        check_value(t, "alu op", 32'(e.alu), 32'(observed.alu));
        check_value(t, "data buffer", 32'(e.dbuf), 32'(observed.dbuf));
        check_value(t, "input latch", 32'(e.ilat), 32'(observed.ilat));
        check_value(t, "reg a", 32'(e.a), 32'(observed.a));
        check_value(t, "reg x", 32'(e.x), 32'(observed.x));
        check_value(t, "reg y", 32'(e.y), 32'(observed.y));
    endtask

    // A test ends at the last row that carries its name
    function automatic bit is_last_row(input int r);
        bit last;
        last = 1'b1;
        for (int j = r + 1; j < `TRACE_LINES; j++) begin
            if (row_name[j] == row_name[r]) last = 1'b0;
        end
        return last;
    endfunction

    task automatic report_test(input int r);
        tests_run++;
        if (test_errors[row_name[r]] == 0) begin
            $display("Test %s passed", row_name[r]);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", row_name[r], test_errors[row_name[r]]);
        end
    endtask

    // Row 0 is the idle vector, checked on every reset cycle
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_row(0);
        end
        rst_n = 1'b1;
    endtask

    task automatic replay_trace();
        for (int r = 0; r < `TRACE_LINES; r++) begin
            clk_enable  = row_ce[r];
            instruction = row_ins[r];
            @(negedge clk);
            check_row(r);
            if (is_last_row(r)) begin
                report_test(r);
            end
        end
    endtask

    // Keep the decoder clocked so an unfinished instruction can drain back to idle
    task automatic wait_for_idle();
        int cycles;
        cycles      = 0;
        clk_enable  = 1'b1;
        instruction = `OP_NOP;
        while (observed !== row_exp[0] && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (observed !== row_exp[0]) begin
            $display("Timed out after %0d cycles waiting for idle outputs", cycles);
            other_failures++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        clk_enable  = 1'b0;
        instruction = '0;
        load_trace();
        if (other_failures == 0) begin
            apply_reset();
            replay_trace();
            wait_for_idle();
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d other failures",
                 tests_run, tests_failed, checks, errors, other_failures);
        if (errors == 0 && other_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
cpu_decode_pkg.sv
opcode_classify.sv
decode_fsm.sv
control_gen.sv
instruction_decode.sv
tb_instruction_decode.sv

/* Makefile */
TOP := tb_instruction_decode

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and replay decode_trace.txt"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

/* decode_trace.txt */
# name clk_enable instruction | mask value status_rw addr_sel mem_rw addr pc alu dbuf ilat a x y
# All hex, without the bar; outputs are those after the rising edge that takes the row
reset   0 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
sec     1 38 01 01 1 0 1 0000 1 00 0 0 0 0 0
sec     1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
tax     1 aa 00 00 1 0 1 0000 1 00 0 0 6 4 0
tax     1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
lda_imm 1 a9 00 00 1 0 1 0000 1 00 0 0 0 0 0
lda_imm 1 5c 00 00 1 0 1 0000 0 00 0 1 0 0 0
lda_imm 1 00 42 00 0 0 1 0000 0 0d 0 2 0 0 0
lda_imm 1 00 00 00 1 0 1 0000 0 0e 0 0 5 0 0
lda_imm 1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
dey     1 88 00 00 1 0 1 0000 1 00 0 0 0 0 0
dey     1 00 42 00 0 0 1 0000 0 0c 0 0 0 0 6
dey     1 00 00 00 1 0 1 0000 0 0e 0 0 0 0 5
dey     1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
adc_zpg 1 65 00 00 1 0 1 0000 1 00 0 0 0 0 0
adc_zpg 1 3c 00 00 1 1 1 003c 1 00 0 0 0 0 0
stall   0 ff 00 00 1 1 1 003c 1 00 0 0 0 0 0
adc_zpg 1 77 00 00 1 0 1 0000 0 00 0 1 0 0 0
adc_zpg 1 00 42 00 0 0 1 0000 0 08 0 2 7 0 0
adc_zpg 1 00 00 00 1 0 1 0000 0 0e 0 0 5 0 0
adc_zpg 1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
sta_abs 1 8d 00 00 1 0 1 0000 1 00 0 0 0 0 0
sta_abs 1 34 00 00 1 0 1 0000 1 00 0 0 0 0 0
sta_abs 1 12 00 00 1 1 1 1234 1 00 0 0 0 0 0
stall   0 a5 00 00 1 1 1 1234 1 00 0 0 0 0 0
sta_abs 1 00 00 00 1 0 1 0000 0 00 0 1 0 0 0
sta_abs 1 00 00 00 0 0 1 0000 0 00 0 0 0 0 0
sta_abs 1 00 00 00 1 0 1 0000 0 00 1 0 7 0 0
sta_abs 1 00 00 00 1 1 0 1234 0 00 2 0 0 0 0
sta_abs 1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
jmp     1 4c 00 00 1 0 1 0000 1 00 0 0 0 0 0
jmp     1 80 00 00 1 0 1 0000 1 00 0 0 0 0 0
jmp     1 c0 00 00 1 0 1 c080 2 00 0 0 0 0 0
stall   0 4c 00 00 1 0 1 c080 2 00 0 0 0 0 0
jmp     1 00 00 00 1 0 1 0000 0 00 0 0 0 0 0
